// ==== design/cmd_engine.sv ====
module cmd_engine #(
   parameter int VEC_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   rx_valid,
   input  spi_cmd_pkg::spi_word_t rx_word,
   output logic                   tx_load,
   output spi_cmd_pkg::spi_word_t tx_word,
   output spi_cmd_pkg::ram_port_t ram,
   input  spi_cmd_pkg::vec_word_t ram_rdata,
   output spi_cmd_pkg::led_t      leds
);
   import spi_cmd_pkg::*;

   localparam int IDX_W = (VEC_DEPTH > 1) ? $clog2(VEC_DEPTH) : 1;
   localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(VEC_DEPTH - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_wr_vec,
      st_rd_vec,
      st_rd_wait
   } state_t;

   state_t state;

   // word being written, or word currently loaded for readout
   logic [IDX_W-1:0] vec_idx;
   logic [IDX_W-1:0] ram_idx;

   logic [15:0] inv_bits;

   spi_frame_t frame;
   spi_frame_t reg_reply;

   assign frame = rx_word;

   // during readout look one word ahead so the RAM output is ready
   // by the time the wait state issues it
   assign ram_idx = (state == st_rd_vec) ? vec_idx + 1'b1 : vec_idx;

   always_comb begin
      ram.we    = (state == st_wr_vec) && rx_valid;
      ram.addr  = 8'(ram_idx);
      ram.wdata = frame.payload;
   end

   // register read replies echo the opcode that asked for them
   always_comb begin
      reg_reply.opcode = frame.opcode;
      if (frame.opcode == rd_leds) begin
         reg_reply.payload = {8'h00, leds};
      end else begin
         reg_reply.payload = {8'h00, inv_bits};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_idle;
         vec_idx  <= '0;
         leds     <= '0;
         inv_bits <= '0;
         tx_load  <= 1'b0;
      end else begin
         tx_load <= 1'b0;
         case (state)
            st_idle: begin
               if (rx_valid) begin
                  case (frame.opcode)
                     init: begin
                        // RAM contents survive init
                        leds     <= '0;
                        inv_bits <= '0;
                        vec_idx  <= '0;
                     end
                     wr_inverted: inv_bits <= ~frame.payload[15:0];
                     rd_inverted: tx_load <= 1'b1;
                     wr_leds:     leds <= frame.payload[15:0];
                     rd_leds:     tx_load <= 1'b1;
                     wr_vec:      state <= st_wr_vec;
                     rd_vec:      state <= st_rd_wait;
                     default: begin
                        // nop and unknown codes
                     end
                  endcase
               end
            end

            st_wr_vec: begin
               if (rx_valid) begin
                  if (vec_idx == IDX_LAST) begin
                     vec_idx <= '0;
                     state   <= st_idle;
                  end else begin
                     vec_idx <= vec_idx + 1'b1;
                  end
               end
            end

            // rdata holds word vec_idx now
            st_rd_wait: begin
               tx_load <= 1'b1;
               state   <= st_rd_vec;
            end

            st_rd_vec: begin
               if (rx_valid) begin
                  if (vec_idx == IDX_LAST) begin
                     vec_idx <= '0;
                     state   <= st_idle;
                  end else begin
                     vec_idx <= vec_idx + 1'b1;
                     state   <= st_rd_wait;
                  end
               end
            end

            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_rd_wait) begin
         tx_word <= spi_frame_t'{opcode: rd_vec, payload: ram_rdata};
      end else if (rx_valid && state == st_idle) begin
         tx_word <= reg_reply;
      end
   end

endmodule

// ==== design/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

   // one full SPI frame, msb first on the wire
   typedef logic [31:0] spi_word_t;

   // frame payload, also one vector element
   typedef logic [23:0] vec_word_t;

   typedef logic [15:0] led_t;

   // unknown codes fall through as nop
   typedef enum logic [7:0] {
      nop         = 8'h00,
      init        = 8'h01,
      wr_inverted = 8'h02,
      rd_inverted = 8'h03,
      wr_leds     = 8'h04,
      rd_leds     = 8'h05,
      wr_vec      = 8'h06,
      rd_vec      = 8'h07
   } cmd_opcode_t;

   typedef struct packed {
      cmd_opcode_t opcode;
      vec_word_t   payload;
   } spi_frame_t;

   typedef struct packed {
      logic        we;
      logic [7:0]  addr;
      vec_word_t   wdata;
   } ram_port_t;

endpackage

// ==== design/spi_cmd_top.sv ====
module spi_cmd_top #(
   parameter int VEC_DEPTH = 4
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               sck,
   input  logic               ss,
   input  logic               mosi,
   output logic               miso,
   output spi_cmd_pkg::led_t  leds
);
   import spi_cmd_pkg::*;

   logic      rx_valid;
   spi_word_t rx_word;
   logic      tx_load;
   spi_word_t tx_word;
   ram_port_t ram;
   vec_word_t ram_rdata;

   spi_slave u_spi_slave (
      .clk      (clk),
      .reset    (reset),
      .sck      (sck),
      .ss       (ss),
      .mosi     (mosi),
      .miso     (miso),
      .rx_valid (rx_valid),
      .rx_word  (rx_word),
      .tx_load  (tx_load),
      .tx_word  (tx_word)
   );

   cmd_engine #(
      .VEC_DEPTH (VEC_DEPTH)
   ) u_cmd_engine (
      .clk       (clk),
      .reset     (reset),
      .rx_valid  (rx_valid),
      .rx_word   (rx_word),
      .tx_load   (tx_load),
      .tx_word   (tx_word),
      .ram       (ram),
      .ram_rdata (ram_rdata),
      .leds      (leds)
   );

   // engine is the only RAM client
   vector_ram #(
      .VEC_DEPTH (VEC_DEPTH)
   ) u_vector_ram (
      .clk   (clk),
      .ram   (ram),
      .rdata (ram_rdata)
   );

endmodule

// ==== design/spi_slave.sv ====
module spi_slave (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sck,
   input  logic                   ss,
   input  logic                   mosi,
   output logic                   miso,
   output logic                   rx_valid,
   output spi_cmd_pkg::spi_word_t rx_word,
   input  logic                   tx_load,
   input  spi_cmd_pkg::spi_word_t tx_word
);
   import spi_cmd_pkg::*;

   // two-flop synchronizers, index 1 is the safe copy
   logic [1:0] sck_sync;
   logic [1:0] ss_sync;
   logic [1:0] mosi_sync;

   // one more stage for edge detection
   logic sck_prev;
   logic ss_prev;

   logic sck_rise;
   logic sck_fall;
   logic ss_fall;
   logic selected;

   logic [4:0] bit_cnt;

   spi_word_t rx_shift;
   spi_word_t tx_shift;
   spi_word_t pending;

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync  <= 2'b00;
         ss_sync   <= 2'b11;
         mosi_sync <= 2'b00;
         sck_prev  <= 1'b0;
         ss_prev   <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[0], sck};
         ss_sync   <= {ss_sync[0], ss};
         mosi_sync <= {mosi_sync[0], mosi};
         sck_prev  <= sck_sync[1];
         ss_prev   <= ss_sync[1];
      end
   end

   assign selected = ~ss_sync[1];
   assign sck_rise = selected & sck_sync[1] & ~sck_prev;
   assign sck_fall = selected & ~sck_sync[1] & sck_prev;
   assign ss_fall  = ss_prev & ~ss_sync[1];

   // receive side, mode 0 samples on the rising edge
   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt  <= 5'd0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (!selected) begin
            bit_cnt <= 5'd0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 5'd1;
            // bit 32 completes the frame, counter wraps to 0
            if (bit_cnt == 5'd31) begin
               rx_valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= {rx_shift[30:0], mosi_sync[1]};
      end
   end

   // frame stays readable until the next one starts shifting in
   assign rx_word = rx_shift;

   // transmit side
   always_ff @(posedge clk) begin
      if (reset) begin
         pending  <= '0;
         tx_shift <= '0;
      end else begin
         if (tx_load) begin
            pending <= tx_word;
         end else if (ss_fall) begin
            // reply used once, next frame sends zeros unless reloaded
            pending <= '0;
         end

         if (ss_fall) begin
            tx_shift <= pending;
         end else if (sck_fall) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
         end
      end
   end

   // msb is on the pin before the first rising sck edge
   assign miso = tx_shift[31];

endmodule

// ==== design/vector_ram.sv ====
module vector_ram #(
   parameter int VEC_DEPTH = 4
) (
   input  logic                   clk,
   input  spi_cmd_pkg::ram_port_t ram,
   output spi_cmd_pkg::vec_word_t rdata
);
   import spi_cmd_pkg::*;

   localparam int IDX_W = (VEC_DEPTH > 1) ? $clog2(VEC_DEPTH) : 1;

   vec_word_t mem [VEC_DEPTH];

   logic [IDX_W-1:0] idx;

   // only the low bits of addr select a word
   assign idx = ram.addr[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (ram.we) begin
         mem[idx] <= ram.wdata;
      end
      // read always enabled, old data on a same-cycle write
      rdata <= mem[idx];
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then scan the simulation log for failures
cd "$(dirname "$0")" &&
verilator --binary --timing -f spi_cmd.f --top-module spi_cmd_tb \
   -o spi_cmd_sim > build.log 2>&1 &&
./obj_dir/spi_cmd_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// ==== spi_cmd.f ====
+incdir+test
design/spi_cmd_pkg.sv
design/spi_slave.sv
design/cmd_engine.sv
design/vector_ram.sv
design/spi_cmd_top.sv
test/spi_cmd_tb.sv

// ==== test/spi_cmd_tasks.svh ====
`ifndef SPI_CMD_TASKS_SVH
`define SPI_CMD_TASKS_SVH

function automatic spi_word_t frame_of(input cmd_opcode_t op, input vec_word_t payload);
   return {op, payload};
endfunction

// mode 0 and msb first, with miso taken just before each rising sck edge
task automatic spi_xfer(input spi_word_t tx, output spi_word_t rx);
   rx   = '0;
   ss   = 1'b0;
   sck  = 1'b0;
   mosi = tx[31];
   repeat (HALF_CYCLES) @(negedge clk);
   for (int i = 31; i >= 0; i--) begin
      rx[i] = miso;
      sck   = 1'b1;
      repeat (HALF_CYCLES) @(negedge clk);
      sck = 1'b0;
      if (i > 0) begin
         mosi = tx[i-1];
      end
      repeat (HALF_CYCLES) @(negedge clk);
   end
   ss   = 1'b1;
   mosi = 1'b0;
   repeat (GAP_CYCLES) @(negedge clk);
endtask

task automatic send_frame(input spi_word_t tx);
   spi_word_t ignored;
   spi_xfer(tx, ignored);
endtask

task automatic check_word(input string name, input spi_word_t expected,
                          input spi_word_t actual);
   if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      test_errors++;
   end
endtask

task automatic check_leds(input string name, input led_t expected, input led_t actual);
   if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      test_errors++;
   end
endtask

task automatic finish_test(input string name);
   tests_run++;
   total_errors += test_errors;
   if (test_errors == 0) begin
      $display("%s: pass", name);
   end else begin
      tests_failed++;
      $display("%s: fail with %0d mismatches", name, test_errors);
   end
   test_errors = 0;
endtask

// rd_vec and then one nop per word to carry the data out
task automatic read_vector_back();
   spi_word_t rx;
   // earlier reply already used up, so the command frame shifts zeros
   spi_xfer(frame_of(rd_vec, '0), rx);
   check_word("miso rd_vec frame", '0, rx);
   for (int i = 0; i < VEC_DEPTH; i++) begin
      spi_xfer(frame_of(nop, '0), rx);
      check_word($sformatf("miso vector word %0d", i), frame_of(rd_vec, vec_data[i]), rx);
   end
endtask

task automatic reset_and_nop();
   spi_word_t rx;
   check_leds("leds", '0, leds);
   spi_xfer(frame_of(nop, '0), rx);
   check_word("miso first nop", '0, rx);
   spi_xfer(frame_of(nop, '0), rx);
   check_word("miso second nop", '0, rx);
   finish_test("reset and nop");
endtask

task automatic leds_write_read();
   spi_word_t rx;
   led_t      value;
   value = 16'hA5C3;
   send_frame(frame_of(wr_leds, {8'h00, value}));
   check_leds("leds", value, leds);
   send_frame(frame_of(rd_leds, '0));
   spi_xfer(frame_of(nop, '0), rx);
   check_word("miso rd_leds reply", frame_of(rd_leds, {8'h00, value}), rx);
   finish_test("leds write and read");
endtask

task automatic inverted_write_read();
   spi_word_t rx;
   vec_word_t payload;
   led_t      inverted;
   payload  = 24'h001234;
   // complement of 0x1234
   inverted = 16'hEDCB;
   send_frame(frame_of(wr_inverted, payload));
   send_frame(frame_of(rd_inverted, '0));
   spi_xfer(frame_of(nop, '0), rx);
   check_word("miso rd_inverted reply", frame_of(rd_inverted, {8'h00, inverted}), rx);
   finish_test("inverted write and read");
endtask

task automatic vector_write_read();
   spi_word_t rnd;
   send_frame(frame_of(wr_vec, '0));
   for (int i = 0; i < VEC_DEPTH; i++) begin
      rnd = $random(seed);
      vec_data[i] = rnd[23:0];
      // the engine must ignore the random top byte
      send_frame(rnd);
   end
   read_vector_back();
   finish_test("vector write and read");
endtask

task automatic init_clears_regs();
   spi_word_t rx;
   send_frame(frame_of(wr_leds, 24'h003C5A));
   send_frame(frame_of(wr_inverted, 24'h00BEEF));
   check_leds("leds before init", 16'h3C5A, leds);
   send_frame(frame_of(init, '0));
   check_leds("leds after init", '0, leds);
   send_frame(frame_of(rd_inverted, '0));
   spi_xfer(frame_of(nop, '0), rx);
   check_word("miso rd_inverted after init", frame_of(rd_inverted, '0), rx);
   read_vector_back();
   finish_test("init clears registers");
endtask

`endif

// ==== test/spi_cmd_tb.sv ====
module spi_cmd_tb;
   import spi_cmd_pkg::*;

   localparam int VEC_DEPTH    = 4;
   localparam int RESET_CYCLES = 8;
   localparam int HALF_CYCLES  = 4;
   localparam int GAP_CYCLES   = 10;

   // select setup, 32 full sck periods, then the gap
   localparam int FRAME_CYCLES = HALF_CYCLES + 64 * HALF_CYCLES + GAP_CYCLES;
   // 2 + 3 + 3 + 10 + 10 frames over the five tests
   localparam int FRAME_COUNT    = 28;
   localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + FRAME_COUNT * FRAME_CYCLES);

   logic clk;
   logic reset;
   logic sck;
   logic ss;
   logic mosi;
   logic miso;
   led_t leds;

   integer seed = 45;
   int     cycle_count = 0;
   int     test_errors = 0;
   int     total_errors = 0;
   int     tests_run = 0;
   int     tests_failed = 0;

   // values written by the vector test, reused after init
   vec_word_t vec_data [VEC_DEPTH];

   spi_cmd_top #(
      .VEC_DEPTH (VEC_DEPTH)
   ) u_spi_cmd_top (
      .clk   (clk),
      .reset (reset),
      .sck   (sck),
      .ss    (ss),
      .mosi  (mosi),
      .miso  (miso),
      .leds  (leds)
   );

   `include "spi_cmd_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run stopped after %0d clock cycles", cycle_count);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      reset = 1'b1;
      sck   = 1'b0;
      ss    = 1'b1;
      mosi  = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      repeat (4) @(negedge clk);

      reset_and_nop();
      leds_write_read();
      inverted_write_read();
      vector_write_read();
      init_clears_regs();

      $display("summary: %0d tests, %0d failed, %0d mismatches",
               tests_run, tests_failed, total_errors);
      if (tests_failed == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
